//--- common/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Datapath widths
`define XLEN                32
`define CSR_ADDR_W          12
`define COUNTER_W           64

// User counters in the read-only space
`define CSR_ADDR_CYCLE      12'hc00
`define CSR_ADDR_CYCLEH     12'hc80

// Machine counters
`define CSR_ADDR_MCYCLE     12'hb00
`define CSR_ADDR_MCYCLEH    12'hb80

// Machine trap setup
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305

// Machine trap handling
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MIP        12'h344

// Cause codes with the interrupt flag in bit 31
`define MCAUSE_ECALL_U      32'h0000_0008
`define MCAUSE_ECALL_M      32'h0000_000b
`define MCAUSE_MTI          32'h8000_0007

// Field positions in mstatus, mie and mip
`define MSTATUS_MIE_BIT     3
`define MSTATUS_MPIE_BIT    7
`define MSTATUS_MPP_LSB     11
`define MTI_BIT             7

`endif

//--- common/csr_cmd_pkg.sv
`default_nettype none

package csr_cmd_pkg;

    // Command carried down the pipeline into the CSR stage
    typedef enum logic [2:0] {
        // No CSR access
        CMD_X     = 3'd0,
        // CSRRW
        CMD_W     = 3'd1,
        // CSRRS
        CMD_S     = 3'd2,
        // CSRRC
        CMD_C     = 3'd3,
        // Also reused for a taken interrupt
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_t;

endpackage

`default_nettype wire

//--- common/riscv_priv_pkg.sv
`default_nettype none

`include "csr_consts.svh"

package riscv_priv_pkg;

    // Only user and machine modes exist here
    typedef enum logic [1:0] {
        MODE_USER    = 2'b00,
        MODE_MACHINE = 2'b11
    } priv_mode_t;

    // mtvec split into base and mode
    typedef struct packed {
        // Word-aligned handler address
        logic [`XLEN-3:0] base;
        // 0 direct, nonzero vectored
        logic [1:0]       mode;
    } mtvec_fields_t;

    // Same word seen by the CSR path and the vector logic
    typedef union packed {
        logic [`XLEN-1:0] raw;
        mtvec_fields_t    fields;
    } mtvec_u;

endpackage

`default_nettype wire

//--- common/csr_trap_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

interface csr_trap_if;
    import csr_cmd_pkg::*;
    import riscv_priv_pkg::*;

    // Command after flush gating
    csr_cmd_t               eff_cmd;
    logic [`CSR_ADDR_W-1:0] eff_addr;

    // One-cycle timer interrupt event and its return PC
    logic                   take_irq;
    logic [`XLEN-1:0]       irq_epc;

    // Architectural state owned by the register file
    priv_mode_t             mode;
    logic                   mstatus_mie;
    priv_mode_t             mstatus_mpp;
    mtvec_u                 mtvec;
    logic [`XLEN-1:0]       mepc;
    logic                   mtip;

    modport ctrl (
        output eff_cmd, eff_addr, take_irq, irq_epc,
        input  mode, mstatus_mie, mtvec, mepc, mtip
    );

    modport regs (
        input  eff_cmd, eff_addr, take_irq, irq_epc,
        output mode, mstatus_mie, mstatus_mpp, mtvec, mepc, mtip
    );

endinterface

`default_nettype wire

//--- csr_file/csr_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_regfile (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire [`XLEN-1:0]        op1_data,
    input  wire [`COUNTER_W-1:0]   cycle,
    input  wire [`COUNTER_W-1:0]   mtime,
    input  wire [`COUNTER_W-1:0]   mtimecmp,
    output logic [`XLEN-1:0]       csr_rdata,
    csr_trap_if.regs               trap
);
    import csr_cmd_pkg::*;
    import riscv_priv_pkg::*;

    // State not exported on the interface
    logic                   mpie;
    logic                   mtie;
    logic [`XLEN-1:0]       mscratch;
    logic [`XLEN-1:0]       mcause;

    // Command held over for the delayed write
    csr_cmd_t               save_cmd;
    logic [`CSR_ADDR_W-1:0] save_addr;
    logic [`XLEN-1:0]       save_op1;

    logic [`XLEN-1:0]       rd_mstatus;
    logic [`XLEN-1:0]       rd_mie;
    logic [`XLEN-1:0]       rd_mip;
    logic [`XLEN-1:0]       rd_value;
    logic                   rd_ok;
    logic                   wr_ok;
    logic                   wr_en;
    logic [`XLEN-1:0]       wdata;
    logic                   timer_hit;

    // Privilege level encoded in address bits 9:8
    assign rd_ok = trap.eff_addr[9:8] <= trap.mode;

    // Bits 11:10 both set means read-only space
    assign wr_ok = (save_addr[11:10] != 2'b11) && (save_addr[9:8] <= trap.mode);

    // Only W, S and C carry a write
    assign wr_en = wr_ok && (save_cmd inside {CMD_W, CMD_S, CMD_C});

    assign timer_hit = mtime >= mtimecmp;

    // Set and clear reuse last cycle's read data
    always_comb begin
        case (save_cmd)
            CMD_W:   wdata = save_op1;
            CMD_S:   wdata = csr_rdata | save_op1;
            CMD_C:   wdata = csr_rdata & ~save_op1;
            default: wdata = '0;
        endcase
    end

    always_comb begin
        rd_mstatus = '0;
        rd_mstatus[`MSTATUS_MIE_BIT] = trap.mstatus_mie;
        rd_mstatus[`MSTATUS_MPIE_BIT] = mpie;
        rd_mstatus[`MSTATUS_MPP_LSB +: 2] = trap.mstatus_mpp;
        rd_mie = '0;
        rd_mie[`MTI_BIT] = mtie;
        rd_mip = '0;
        rd_mip[`MTI_BIT] = trap.mtip;
        // Unlisted addresses read zero
        case (trap.eff_addr)
            `CSR_ADDR_CYCLE,
            `CSR_ADDR_MCYCLE:   rd_value = cycle[`XLEN-1:0];
            `CSR_ADDR_CYCLEH,
            `CSR_ADDR_MCYCLEH:  rd_value = cycle[`COUNTER_W-1:`XLEN];
            `CSR_ADDR_MSTATUS:  rd_value = rd_mstatus;
            `CSR_ADDR_MIE:      rd_value = rd_mie;
            `CSR_ADDR_MTVEC:    rd_value = trap.mtvec.raw;
            `CSR_ADDR_MSCRATCH: rd_value = mscratch;
            `CSR_ADDR_MEPC:     rd_value = trap.mepc;
            `CSR_ADDR_MCAUSE:   rd_value = mcause;
            `CSR_ADDR_MIP:      rd_value = rd_mip;
            default:            rd_value = '0;
        endcase
    end

    // Address and operand held for the delayed write
    always_ff @(posedge clk) begin
        save_addr <= trap.eff_addr;
        save_op1  <= op1_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            save_cmd         <= CMD_X;
            csr_rdata        <= '0;
            trap.mode        <= MODE_MACHINE;
            trap.mstatus_mpp <= MODE_MACHINE;
            trap.mstatus_mie <= 1'b0;
            trap.mtvec.raw   <= '0;
            trap.mepc        <= '0;
            trap.mtip        <= 1'b0;
            mpie             <= 1'b0;
            mtie             <= 1'b0;
            mscratch         <= '0;
            mcause           <= '0;
        end else begin
            save_cmd  <= trap.eff_cmd;
            csr_rdata <= rd_ok ? rd_value : '0;

            if (trap.take_irq) begin
                // Timer interrupt into machine mode
                mcause           <= `MCAUSE_MTI;
                trap.mepc        <= trap.irq_epc;
                trap.mstatus_mpp <= trap.mode;
                mpie             <= trap.mstatus_mie;
                trap.mstatus_mie <= 1'b0;
                trap.mode        <= MODE_MACHINE;
            end else begin
                // Pending bit holds during the interrupt edge
                trap.mtip <= trap.mstatus_mie && mtie && timer_hit;
                case (trap.eff_cmd)
                    CMD_ECALL: begin
                        mcause <= (trap.mode == MODE_USER) ? `MCAUSE_ECALL_U
                                                           : `MCAUSE_ECALL_M;
                        trap.mode <= MODE_MACHINE;
                    end
                    CMD_MRET: begin
                        trap.mstatus_mie <= mpie;
                        trap.mode        <= trap.mstatus_mpp;
                        mpie             <= 1'b1;
                        trap.mstatus_mpp <= MODE_USER;
                    end
                    default: begin
                    end
                endcase
            end

            // Delayed write lands last and wins on overlap
            if (wr_en) begin
                case (save_addr)
                    `CSR_ADDR_MSTATUS: begin
                        trap.mstatus_mie <= wdata[`MSTATUS_MIE_BIT];
                        mpie             <= wdata[`MSTATUS_MPIE_BIT];
                        // Unsupported MPP encodings fall back to machine
                        trap.mstatus_mpp <= (wdata[`MSTATUS_MPP_LSB +: 2] == 2'b00) ?
                                            MODE_USER : MODE_MACHINE;
                    end
                    `CSR_ADDR_MIE:      mtie <= wdata[`MTI_BIT];
                    `CSR_ADDR_MTVEC:    trap.mtvec.raw <= wdata;
                    `CSR_ADDR_MSCRATCH: mscratch <= wdata;
                    `CSR_ADDR_MEPC:     trap.mepc <= {wdata[`XLEN-1:2], 2'b00};
                    `CSR_ADDR_MCAUSE:   mcause <= wdata;
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- trap/csr_trap_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_trap_ctrl (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         flush,
    input  wire csr_cmd_pkg::csr_cmd_t  csr_cmd,
    input  wire [`CSR_ADDR_W-1:0]       csr_addr,
    input  wire                         interrupt_ready,
    input  wire [`XLEN-1:0]             fetch_pc,
    output csr_cmd_pkg::csr_cmd_t       csr_cmd_out,
    output logic [`XLEN-1:0]            trap_vector,
    csr_trap_if.ctrl                    trap
);
    import csr_cmd_pkg::*;
    import riscv_priv_pkg::*;

    // Offset of the timer entry in a vectored table
    localparam logic [`XLEN-1:0] MTI_VEC_OFFSET = `MTI_BIT * 4;

    logic             irq_enabled;
    logic             take_irq;
    logic [`XLEN-1:0] base_addr;
    logic [`XLEN-1:0] irq_addr;

    // Flushed command turns into an idle access to 0xfff
    assign trap.eff_cmd  = flush ? CMD_X : csr_cmd;
    assign trap.eff_addr = flush ? '1 : csr_addr;

    // Global enable is MIE in machine mode and always on in user mode
    assign irq_enabled = (trap.mode == MODE_USER) || trap.mstatus_mie;

    // A flush cycle never takes the interrupt
    assign take_irq      = trap.mtip && interrupt_ready && irq_enabled && !flush;
    assign trap.take_irq = take_irq;
    // Return address kept word aligned
    assign trap.irq_epc  = {fetch_pc[`XLEN-1:2], 2'b00};

    assign base_addr = {trap.mtvec.fields.base, 2'b00};

    // Vectored mode jumps to base + 4 * cause
    assign irq_addr = (trap.mtvec.fields.mode == 2'b00) ? base_addr
                                                        : base_addr + MTI_VEC_OFFSET;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_cmd_out <= CMD_X;
            trap_vector <= '0;
        end else if (take_irq) begin
            // Interrupt reported downstream as an ECALL
            csr_cmd_out <= CMD_ECALL;
            trap_vector <= irq_addr;
        end else begin
            csr_cmd_out <= trap.eff_cmd;
            case (trap.eff_cmd)
                CMD_ECALL: trap_vector <= base_addr;
                CMD_MRET:  trap_vector <= trap.mepc;
                // Vector holds otherwise
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_stage_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_stage_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         flush,
    input  wire csr_cmd_pkg::csr_cmd_t  csr_cmd,
    input  wire [`CSR_ADDR_W-1:0]       csr_addr,
    input  wire [`XLEN-1:0]             op1_data,
    input  wire                         interrupt_ready,
    input  wire [`XLEN-1:0]             fetch_pc,
    input  wire [`COUNTER_W-1:0]        cycle,
    input  wire [`COUNTER_W-1:0]        mtime,
    input  wire [`COUNTER_W-1:0]        mtimecmp,
    output csr_cmd_pkg::csr_cmd_t       csr_cmd_out,
    output logic [`XLEN-1:0]            csr_rdata,
    output logic [`XLEN-1:0]            trap_vector,
    output logic                        stall_may_interrupt
);

    // Link between trap decisions and CSR state
    csr_trap_if trap_link ();

    csr_trap_ctrl u_trap_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .csr_cmd         (csr_cmd),
        .csr_addr        (csr_addr),
        .interrupt_ready (interrupt_ready),
        .fetch_pc        (fetch_pc),
        .csr_cmd_out     (csr_cmd_out),
        .trap_vector     (trap_vector),
        .trap            (trap_link)
    );

    csr_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .op1_data  (op1_data),
        .cycle     (cycle),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .csr_rdata (csr_rdata),
        .trap      (trap_link)
    );

    // Registered pending bit lets earlier stages drain
    assign stall_may_interrupt = trap_link.mtip;

endmodule

`default_nettype wire

//--- dv/csr_stage_sva.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_stage_sva (
    input wire                         clk,
    input wire                         rst_n,
    input wire                         flush,
    input wire csr_cmd_pkg::csr_cmd_t  csr_cmd_out,
    input wire [`XLEN-1:0]             trap_vector,
    input wire                         stall_may_interrupt
);
    import csr_cmd_pkg::*;

    // Handler and return addresses stay word aligned
    a_vec_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        trap_vector[1:0] == 2'b00)
        else $error("trap_vector has low bits set");

    // Pending flag cleared by reset
    a_stall_in_reset: assert property (@(posedge clk)
        !rst_n |=> !stall_may_interrupt)
        else $error("stall_may_interrupt high after a reset edge");

    // First active cycle still sees no pending interrupt
    a_stall_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |=> !stall_may_interrupt)
        else $error("stall_may_interrupt high right after reset release");

    // Flushed command leaves the stage as idle
    a_flush_idle: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (csr_cmd_out == CMD_X))
        else $error("csr_cmd_out not idle after a flush");

endmodule

`default_nettype wire

//--- dv/csr_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_stage_tb;
    import csr_cmd_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 2;
    localparam logic [31:0] SEED = 32'h36e283d6;
    localparam logic [`COUNTER_W-1:0] CYCLE_VAL = 64'h0123_4567_89ab_cdef;
    localparam logic [`XLEN-1:0] FETCH_PC = 32'h0000_2468;

    // Expected fields belong to the cycle after the row is driven
    typedef struct {
        string                  name;
        csr_cmd_t               cmd;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       op1;
        logic                   flush;
        logic                   irq_ready;
        logic [`COUNTER_W-1:0]  mtime;
        logic [`COUNTER_W-1:0]  mtimecmp;
        logic [`XLEN-1:0]       exp_rdata;
        csr_cmd_t               exp_cmd;
        logic                   chk_vec;
        logic [`XLEN-1:0]       exp_vec;
        logic                   exp_stall;
    } row_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   flush;
    csr_cmd_t               csr_cmd;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`XLEN-1:0]       op1_data;
    logic                   interrupt_ready;
    logic [`XLEN-1:0]       fetch_pc;
    logic [`COUNTER_W-1:0]  cycle;
    logic [`COUNTER_W-1:0]  mtime;
    logic [`COUNTER_W-1:0]  mtimecmp;
    csr_cmd_t               csr_cmd_out;
    logic [`XLEN-1:0]       csr_rdata;
    logic [`XLEN-1:0]       trap_vector;
    logic                   stall_may_interrupt;

    row_t rows[$];
    logic table_ready = 1'b0;

    csr_stage_top uut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .flush               (flush),
        .csr_cmd             (csr_cmd),
        .csr_addr            (csr_addr),
        .op1_data            (op1_data),
        .interrupt_ready     (interrupt_ready),
        .fetch_pc            (fetch_pc),
        .cycle               (cycle),
        .mtime               (mtime),
        .mtimecmp            (mtimecmp),
        .csr_cmd_out         (csr_cmd_out),
        .csr_rdata           (csr_rdata),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

    bind csr_stage_top csr_stage_sva u_sva (
        .clk                 (clk),
        .rst_n               (rst_n),
        .flush               (flush),
        .csr_cmd_out         (csr_cmd_out),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_cmd(input string name, input csr_cmd_t exp, input csr_cmd_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    // mstatus word built from its three fields
    function automatic logic [31:0] mstatus_word(input logic mie, input logic mpie,
                                                 input logic [1:0] mpp);
        logic [31:0] w;
        w = '0;
        w[`MSTATUS_MIE_BIT] = mie;
        w[`MSTATUS_MPIE_BIT] = mpie;
        w[`MSTATUS_MPP_LSB +: 2] = mpp;
        return w;
    endfunction

    task automatic add_row(input string name, input csr_cmd_t cmd, input logic [11:0] addr,
                           input logic [31:0] op1, input logic [31:0] exp_rdata,
                           input logic timer_on = 1'b0, input logic exp_stall = 1'b0,
                           input logic flush_in = 1'b0, input logic irq_in = 1'b0,
                           input logic chk_vec = 1'b0, input logic [31:0] exp_vec = '0);
        row_t r;
        r.name = name;
        r.cmd = cmd;
        r.addr = addr;
        r.op1 = op1;
        r.flush = flush_in;
        r.irq_ready = irq_in;
        // Timer compare met or not
        r.mtime = timer_on ? 64'd200 : 64'd50;
        r.mtimecmp = 64'd100;
        r.exp_rdata = exp_rdata;
        r.chk_vec = chk_vec;
        r.exp_vec = exp_vec;
        r.exp_stall = exp_stall;
        // Taken interrupt leaves as ECALL and a flushed command as idle
        if (irq_in) begin
            r.exp_cmd = CMD_ECALL;
        end else if (flush_in) begin
            r.exp_cmd = CMD_X;
        end else begin
            r.exp_cmd = cmd;
        end
        rows.push_back(r);
    endtask

    task automatic add_idle(input string name, input logic timer_on = 1'b0,
                            input logic exp_stall = 1'b0);
        add_row(name, CMD_X, 12'h000, '0, '0, timer_on, exp_stall);
    endtask

    task automatic build_table();
        logic [31:0] val_a;
        logic [31:0] val_b;
        logic [31:0] set_mask;
        logic [31:0] clr_mask;
        logic [31:0] scratch;
        val_a = $urandom();
        val_b = $urandom();
        set_mask = $urandom();
        clr_mask = $urandom();
        scratch = (val_b | set_mask) & ~clr_mask;
        // Reads two rows after a write see its value
        add_row("w_scratch_a", CMD_W, `CSR_ADDR_MSCRATCH, val_a, 32'h0);
        add_row("w_scratch_b", CMD_W, `CSR_ADDR_MSCRATCH, val_b, 32'h0);
        add_row("rd_scratch_a", CMD_X, `CSR_ADDR_MSCRATCH, '0, val_a);
        add_row("rd_scratch_b", CMD_X, `CSR_ADDR_MSCRATCH, '0, val_b);
        add_row("set_scratch", CMD_S, `CSR_ADDR_MSCRATCH, set_mask, val_b);
        add_idle("idle_set");
        add_row("clr_scratch", CMD_C, `CSR_ADDR_MSCRATCH, clr_mask, val_b | set_mask);
        add_idle("idle_clr");
        add_row("rd_scratch_sc", CMD_X, `CSR_ADDR_MSCRATCH, '0, scratch);
        // Counter halves, unknown address and read-only space
        add_row("rd_cycle", CMD_X, `CSR_ADDR_CYCLE, '0, CYCLE_VAL[31:0]);
        add_row("rd_cycleh", CMD_X, `CSR_ADDR_CYCLEH, '0, CYCLE_VAL[63:32]);
        add_row("rd_unknown", CMD_X, 12'h7c0, '0, 32'h0);
        add_row("w_cycle", CMD_W, `CSR_ADDR_CYCLE, 32'hffff_ffff, CYCLE_VAL[31:0]);
        add_idle("idle_cycle");
        add_row("rd_cycle_again", CMD_X, `CSR_ADDR_CYCLE, '0, CYCLE_VAL[31:0]);
        // mepc drops bits 1:0
        add_row("w_mepc", CMD_W, `CSR_ADDR_MEPC, 32'h0000_1237, 32'h0);
        add_row("w_mtvec_direct", CMD_W, `CSR_ADDR_MTVEC, 32'h0000_0400, 32'h0);
        add_row("rd_mepc", CMD_X, `CSR_ADDR_MEPC, '0, 32'h0000_1234);
        // Flushed write
        add_row("w_scratch_flushed", CMD_W, `CSR_ADDR_MSCRATCH, ~scratch, 32'h0,
                1'b0, 1'b0, 1'b1);
        add_idle("idle_flush");
        add_row("rd_scratch_kept", CMD_X, `CSR_ADDR_MSCRATCH, '0, scratch);
        // ECALL, MRET into user mode and ECALL from user
        add_row("ecall_m", CMD_ECALL, 12'h000, '0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0,
                1'b1, 32'h0000_0400);
        add_row("rd_mcause_m", CMD_X, `CSR_ADDR_MCAUSE, '0, `MCAUSE_ECALL_M);
        add_row("w_mstatus_mpp_u", CMD_W, `CSR_ADDR_MSTATUS, 32'h0,
                mstatus_word(1'b0, 1'b0, 2'b11));
        add_idle("idle_mpp");
        add_row("rd_mstatus_u", CMD_X, `CSR_ADDR_MSTATUS, '0, mstatus_word(1'b0, 1'b0, 2'b00));
        add_row("mret", CMD_MRET, 12'h000, '0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0,
                1'b1, 32'h0000_1234);
        add_row("rd_mstatus_denied", CMD_X, `CSR_ADDR_MSTATUS, '0, 32'h0);
        add_row("ecall_u", CMD_ECALL, 12'h000, '0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0,
                1'b1, 32'h0000_0400);
        add_row("rd_mcause_u", CMD_X, `CSR_ADDR_MCAUSE, '0, `MCAUSE_ECALL_U);
        // Timer interrupt with vectored mtvec
        add_row("w_mtvec_vec", CMD_W, `CSR_ADDR_MTVEC, 32'h0000_0401, 32'h0000_0400);
        add_row("w_mie_mtie", CMD_W, `CSR_ADDR_MIE, 32'h1 << `MTI_BIT, 32'h0);
        add_row("set_mstatus_mie", CMD_S, `CSR_ADDR_MSTATUS, 32'h1 << `MSTATUS_MIE_BIT,
                mstatus_word(1'b0, 1'b1, 2'b00));
        // MIE lands on this edge and the pending bit one cycle later
        add_idle("timer_mie_landing", 1'b1, 1'b0);
        add_idle("timer_pending", 1'b1, 1'b1);
        add_row("timer_irq", CMD_X, 12'h000, '0, 32'h0, 1'b1, 1'b1, 1'b0, 1'b1,
                1'b1, 32'h0000_0400 + 32'd28);
        add_row("rd_mepc_irq", CMD_X, `CSR_ADDR_MEPC, '0, FETCH_PC);
        add_row("rd_mcause_irq", CMD_X, `CSR_ADDR_MCAUSE, '0, `MCAUSE_MTI);
        add_row("rd_mstatus_irq", CMD_X, `CSR_ADDR_MSTATUS, '0,
                mstatus_word(1'b0, 1'b1, 2'b11));
    endtask

    task automatic apply_row(input row_t r);
        csr_cmd = r.cmd;
        csr_addr = r.addr;
        op1_data = r.op1;
        flush = r.flush;
        interrupt_ready = r.irq_ready;
        mtime = r.mtime;
        mtimecmp = r.mtimecmp;
    endtask

    task automatic check_row(input row_t r);
        check_word({r.name, " csr_rdata"}, r.exp_rdata, csr_rdata);
        check_cmd({r.name, " csr_cmd_out"}, r.exp_cmd, csr_cmd_out);
        if (r.chk_vec) begin
            check_word({r.name, " trap_vector"}, r.exp_vec, trap_vector);
        end
        check_flag({r.name, " stall_may_interrupt"}, r.exp_stall, stall_may_interrupt);
    endtask

    // Watchdog sized from the table
    initial begin
        wait (table_ready);
        #(CLK_PERIOD * (rows.size() + RST_CYCLES + 10));
        $display("Timeout: the table of %0d rows did not finish in time", rows.size());
        stop_on_failure();
    end

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        flush = 1'b0;
        csr_cmd = CMD_X;
        csr_addr = '0;
        op1_data = '0;
        interrupt_ready = 1'b0;
        fetch_pc = FETCH_PC;
        cycle = CYCLE_VAL;
        mtime = '0;
        mtimecmp = '1;
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #5;
        rst_n = 1'b1;
        check_cmd("reset csr_cmd_out", CMD_X, csr_cmd_out);
        check_word("reset csr_rdata", 32'h0, csr_rdata);
        check_word("reset trap_vector", 32'h0, trap_vector);
        check_flag("reset stall_may_interrupt", 1'b0, stall_may_interrupt);
        // Drive at edge plus 5 and sample at edge plus 4
        foreach (rows[i]) begin
            apply_row(rows[i]);
            @(posedge clk);
            #4;
            check_row(rows[i]);
            #1;
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/csr_cmd_pkg.sv
common/riscv_priv_pkg.sv
common/csr_trap_if.sv
csr_file/csr_regfile.sv
trap/csr_trap_ctrl.sv
verilog/csr_stage_top.sv
dv/csr_stage_sva.sv
dv/csr_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the CSR stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module csr_stage_tb -f sources.f -o csr_stage_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/csr_stage_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

exit 0
